//--- hdl/csr_pkg.sv
package csr_pkg;

   // ----------------------------------------------------------
   // widths and privilege modes
   // ----------------------------------------------------------
   localparam int RSZ    = 32;
   localparam int CSR_AW = 12;

   // privilege level as seen by the CSR read path
   typedef logic [1:0] mode_t;

   localparam mode_t U_MODE = 2'd0;
   localparam mode_t S_MODE = 2'd1;
   localparam mode_t M_MODE = 2'd3;

   // counter view of an address: page selects lo/hi shadow block,
   // index selects the mcounteren bit
   typedef struct packed {
      logic [6:0] page;
      logic [4:0] idx;
   } cntr_addr_t;

   typedef union packed {
      logic [CSR_AW-1:0] raw;
      cntr_addr_t        cntr;
   } csr_addr_u;

   // pages of the user counter shadows, 12'hC00 and 12'hC80
   localparam logic [6:0] CNTR_PAGE_LO = 7'h60;
   localparam logic [6:0] CNTR_PAGE_HI = 7'h64;

   // ----------------------------------------------------------
   // CSR addresses
   // ----------------------------------------------------------
   // machine trap setup and handling
   localparam logic [CSR_AW-1:0] CSR_MSTATUS       = 12'h300;
   localparam logic [CSR_AW-1:0] CSR_MISA          = 12'h301;
   localparam logic [CSR_AW-1:0] CSR_MTVEC         = 12'h305;
   localparam logic [CSR_AW-1:0] CSR_MCOUNTEREN    = 12'h306;
   localparam logic [CSR_AW-1:0] CSR_MCOUNTINHIBIT = 12'h320;
   localparam logic [CSR_AW-1:0] CSR_MSCRATCH      = 12'h340;
   localparam logic [CSR_AW-1:0] CSR_MEPC          = 12'h341;
   localparam logic [CSR_AW-1:0] CSR_MCAUSE        = 12'h342;
   localparam logic [CSR_AW-1:0] CSR_MTVAL         = 12'h343;
   // machine counters, 32-bit halves
   localparam logic [CSR_AW-1:0] CSR_MCYCLE        = 12'hB00;
   localparam logic [CSR_AW-1:0] CSR_MINSTRET      = 12'hB02;
   localparam logic [CSR_AW-1:0] CSR_MCYCLEH       = 12'hB80;
   localparam logic [CSR_AW-1:0] CSR_MINSTRETH     = 12'hB82;
   // user read-only shadows
   localparam logic [CSR_AW-1:0] CSR_CYCLE         = 12'hC00;
   localparam logic [CSR_AW-1:0] CSR_TIME          = 12'hC01;
   localparam logic [CSR_AW-1:0] CSR_INSTRET       = 12'hC02;
   localparam logic [CSR_AW-1:0] CSR_CYCLEH        = 12'hC80;
   localparam logic [CSR_AW-1:0] CSR_TIMEH         = 12'hC81;
   localparam logic [CSR_AW-1:0] CSR_INSTRETH      = 12'hC82;
   // machine information, read only
   localparam logic [CSR_AW-1:0] CSR_MVENDORID     = 12'hF11;
   localparam logic [CSR_AW-1:0] CSR_MARCHID       = 12'hF12;
   localparam logic [CSR_AW-1:0] CSR_MIMPID        = 12'hF13;
   localparam logic [CSR_AW-1:0] CSR_MHARTID       = 12'hF14;

   // ----------------------------------------------------------
   // read data source select
   // ----------------------------------------------------------
   typedef enum logic [4:0] {
      SEL_NONE, SEL_MSTATUS, SEL_MISA, SEL_MTVEC, SEL_MCOUNTEREN,
      SEL_MCOUNTINHIBIT, SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL,
      SEL_CYCLE_LO, SEL_CYCLE_HI, SEL_INSTRET_LO, SEL_INSTRET_HI,
      SEL_TIME_LO, SEL_TIME_HI, SEL_VENDOR, SEL_ARCH, SEL_IMP, SEL_HART
   } csr_sel_e;

endpackage

//--- hdl/csr_rd_decode.sv
`timescale 1ns/1ns

module csr_rd_decode
(
   input  csr_pkg::csr_addr_u addr,
   output csr_pkg::csr_sel_e  sel,
   output logic               is_cntr_shadow
);
   import csr_pkg::*;

   always_comb
   begin
      // unknown and dropped CSRs fall through to no source
      sel = SEL_NONE;

      case (addr.raw)
         // ----------------------------------------------------------
         // machine trap setup and handling
         // ----------------------------------------------------------
         CSR_MSTATUS:       sel = SEL_MSTATUS;
         CSR_MISA:          sel = SEL_MISA;
         CSR_MTVEC:         sel = SEL_MTVEC;
         CSR_MCOUNTEREN:    sel = SEL_MCOUNTEREN;
         CSR_MCOUNTINHIBIT: sel = SEL_MCOUNTINHIBIT;
         CSR_MSCRATCH:      sel = SEL_MSCRATCH;
         CSR_MEPC:          sel = SEL_MEPC;
         CSR_MCAUSE:        sel = SEL_MCAUSE;
         CSR_MTVAL:         sel = SEL_MTVAL;

         // ----------------------------------------------------------
         // machine counters
         // ----------------------------------------------------------
         CSR_MCYCLE:        sel = SEL_CYCLE_LO;
         CSR_MCYCLEH:       sel = SEL_CYCLE_HI;
         CSR_MINSTRET:      sel = SEL_INSTRET_LO;
         CSR_MINSTRETH:     sel = SEL_INSTRET_HI;

         // ----------------------------------------------------------
         // user shadows, same sources as the machine counters
         // ----------------------------------------------------------
         CSR_CYCLE:         sel = SEL_CYCLE_LO;
         CSR_CYCLEH:        sel = SEL_CYCLE_HI;
         CSR_TIME:          sel = SEL_TIME_LO;
         CSR_TIMEH:         sel = SEL_TIME_HI;
         CSR_INSTRET:       sel = SEL_INSTRET_LO;
         CSR_INSTRETH:      sel = SEL_INSTRET_HI;

         // information registers
         CSR_MVENDORID:     sel = SEL_VENDOR;
         CSR_MARCHID:       sel = SEL_ARCH;
         CSR_MIMPID:        sel = SEL_IMP;
         CSR_MHARTID:       sel = SEL_HART;

         default:           sel = SEL_NONE;
      endcase

      // shadow flag comes from the page/index view, not the case above
      // only cycle, time and instret (index 0..2) are kept; hpm shadows dropped
      is_cntr_shadow = ((addr.cntr.page == CNTR_PAGE_LO) ||
                        (addr.cntr.page == CNTR_PAGE_HI)) &&
                       (addr.cntr.idx <= 5'd2);

      // both decodes must agree on which addresses are shadows
      if (is_cntr_shadow)
      begin
         assert (sel != SEL_NONE)
            else $error("csr_rd_decode: shadow address %h has no source", addr.raw);
      end
   end

endmodule

//--- hdl/csr_cntr_access.sv
`timescale 1ns/1ns

module csr_cntr_access
(
   input  csr_pkg::csr_addr_u       addr,
   input  csr_pkg::mode_t           mode,
   input  logic [csr_pkg::RSZ-1:0]  mcounteren,
   output logic                     cntr_ok
);
   import csr_pkg::*;

   // enable bit for this counter
   logic en_bit;

   // index field picks cycle (0), time (1) or instret (2)
   assign en_bit = mcounteren[addr.cntr.idx];

   always_comb
   begin
      case (mode)
         // machine mode always reads its counters
         M_MODE:
            cntr_ok = 1'b1;
         // no S-mode CSRs here, so S and U both go through mcounteren
         S_MODE:
            cntr_ok = en_bit;
         U_MODE:
            cntr_ok = en_bit;
         // reserved mode value 2
         default:
            cntr_ok = 1'b0;
      endcase
   end

endmodule

//--- hdl/csr_rd_mux.sv
`timescale 1ns/1ns

module csr_rd_mux
#(
   parameter bit                      IALIGN16 = 1'b0,
   parameter logic [csr_pkg::RSZ-1:0] HART_ID  = '0
)
(
   input  csr_pkg::csr_sel_e           sel,
   input  logic                        is_cntr_shadow,
   input  logic                        cntr_ok,
   input  logic [csr_pkg::RSZ-1:0]     mstatus,
   input  logic [csr_pkg::RSZ-1:0]     misa,
   input  logic [csr_pkg::RSZ-1:0]     mtvec,
   input  logic [csr_pkg::RSZ-1:0]     mcounteren,
   input  logic [csr_pkg::RSZ-1:0]     mcountinhibit,
   input  logic [csr_pkg::RSZ-1:0]     mscratch,
   input  logic [csr_pkg::RSZ-1:0]     mepc,
   input  logic [csr_pkg::RSZ-1:0]     mcause,
   input  logic [csr_pkg::RSZ-1:0]     mtval,
   input  logic [csr_pkg::RSZ-1:0]     mvendorid,
   input  logic [csr_pkg::RSZ-1:0]     marchid,
   input  logic [csr_pkg::RSZ-1:0]     mimpid,
   input  logic [2*csr_pkg::RSZ-1:0]   mcycle,
   input  logic [2*csr_pkg::RSZ-1:0]   minstret,
   input  logic [2*csr_pkg::RSZ-1:0]   mtime,
   output logic [csr_pkg::RSZ-1:0]     data,
   output logic                        exists
);
   import csr_pkg::*;

   // mepc alignment: bit 0 always clear, bit 1 also clear without 16-bit instructions
   localparam logic [RSZ-1:0] EPC_MASK = IALIGN16 ? {{(RSZ-1){1'b1}}, 1'b0}
                                                  : {{(RSZ-2){1'b1}}, 2'b00};

   // selected value before the availability gate
   logic [RSZ-1:0] src;

   // ----------------------------------------------------------
   // source select
   // ----------------------------------------------------------
   always_comb
   begin
      case (sel)
         SEL_MSTATUS:       src = mstatus;
         SEL_MISA:          src = misa;
         SEL_MTVEC:         src = mtvec;
         SEL_MCOUNTEREN:    src = mcounteren;
         SEL_MCOUNTINHIBIT: src = mcountinhibit;
         SEL_MSCRATCH:      src = mscratch;
         SEL_MEPC:          src = mepc & EPC_MASK;
         SEL_MCAUSE:        src = mcause;
         SEL_MTVAL:         src = mtval;
         // 64-bit counters split into halves
         SEL_CYCLE_LO:      src = mcycle[RSZ-1:0];
         SEL_CYCLE_HI:      src = mcycle[2*RSZ-1:RSZ];
         SEL_INSTRET_LO:    src = minstret[RSZ-1:0];
         SEL_INSTRET_HI:    src = minstret[2*RSZ-1:RSZ];
         SEL_TIME_LO:       src = mtime[RSZ-1:0];
         SEL_TIME_HI:       src = mtime[2*RSZ-1:RSZ];
         // id registers
         SEL_VENDOR:        src = mvendorid;
         SEL_ARCH:          src = marchid;
         SEL_IMP:           src = mimpid;
         SEL_HART:          src = HART_ID;
         default:           src = '0;
      endcase
   end

   // ----------------------------------------------------------
   // availability and output gate
   // ----------------------------------------------------------
   // a shadow exists only when the privilege check passes
   assign exists = (sel != SEL_NONE) && (!is_cntr_shadow || cntr_ok);

   // denied reads return zero, high halves included
   assign data = exists ? src : '0;

endmodule

//--- hdl/csr_rd_port.sv
`timescale 1ns/1ns

module csr_rd_port
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       req,
   input  csr_pkg::csr_addr_u         addr,
   input  csr_pkg::mode_t             mode,
   input  logic [csr_pkg::RSZ-1:0]    rd_data_next,
   input  logic                       rd_avail_next,
   output logic                       ack,
   output csr_pkg::csr_addr_u         lat_addr,
   output csr_pkg::mode_t             lat_mode,
   output logic [csr_pkg::RSZ-1:0]    rd_data,
   output logic                       rd_avail
);
   import csr_pkg::*;

   // IDLE waits for req, LOOKUP lets the decode path settle, HOLD keeps ack up
   typedef enum logic [1:0] {IDLE, LOOKUP, HOLD} state_e;

   state_e state;
   logic   start;

   // new request accepted only with ack already low
   assign start = (state == IDLE) && req && !ack;

   // ----------------------------------------------------------
   // sequencer and ack side of the handshake
   // ----------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= IDLE;
         ack      <= 1'b0;
         rd_avail <= 1'b0;
         rd_data  <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (start)
                  state <= LOOKUP;
            end
            // result of the latched request is ready, capture and ack
            LOOKUP:
            begin
               rd_data  <= rd_data_next;
               rd_avail <= rd_avail_next;
               ack      <= 1'b1;
               state    <= HOLD;
            end
            // holding req stalls here with the result frozen
            HOLD:
            begin
               if (!req)
               begin
                  ack   <= 1'b0;
                  state <= IDLE;
               end
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   // request latch, address and mode only
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         lat_addr <= addr;
         lat_mode <= mode;
      end
   end

   // ----------------------------------------------------------
   // protocol checks
   // ----------------------------------------------------------
   // ack only answers a request that was seen
   a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> $past(req))
      else $error("csr_rd_port: ack rose without req");

   // the address feeding the lookup cannot move under an ack
   a_addr_stable: assert property (@(posedge clk) disable iff (rst)
      ack |-> $stable(lat_addr.raw))
      else $error("csr_rd_port: lat_addr changed while ack high");

endmodule

//--- hdl/csr_rd_unit.sv
`timescale 1ns/1ns

module csr_rd_unit
#(
   parameter bit                      IALIGN16 = 1'b0,
   parameter logic [csr_pkg::RSZ-1:0] HART_ID  = '0
)
(
   input  logic                       clk,
   input  logic                       rst,
   // four-phase read port
   input  logic                       req,
   output logic                       ack,
   input  csr_pkg::csr_addr_u         addr,
   input  csr_pkg::mode_t             mode,
   output logic [csr_pkg::RSZ-1:0]    rd_data,
   output logic                       rd_avail,
   // CSR contents
   input  logic [csr_pkg::RSZ-1:0]    mstatus,
   input  logic [csr_pkg::RSZ-1:0]    misa,
   input  logic [csr_pkg::RSZ-1:0]    mtvec,
   input  logic [csr_pkg::RSZ-1:0]    mcounteren,
   input  logic [csr_pkg::RSZ-1:0]    mcountinhibit,
   input  logic [csr_pkg::RSZ-1:0]    mscratch,
   input  logic [csr_pkg::RSZ-1:0]    mepc,
   input  logic [csr_pkg::RSZ-1:0]    mcause,
   input  logic [csr_pkg::RSZ-1:0]    mtval,
   input  logic [csr_pkg::RSZ-1:0]    mvendorid,
   input  logic [csr_pkg::RSZ-1:0]    marchid,
   input  logic [csr_pkg::RSZ-1:0]    mimpid,
   input  logic [2*csr_pkg::RSZ-1:0]  mcycle,
   input  logic [2*csr_pkg::RSZ-1:0]  minstret,
   input  logic [2*csr_pkg::RSZ-1:0]  mtime
);
   import csr_pkg::*;

   // latched request
   csr_addr_u      lat_addr;
   mode_t          lat_mode;

   // combinational lookup path
   csr_sel_e       sel;
   logic           is_cntr_shadow;
   logic           cntr_ok;
   logic [RSZ-1:0] rd_data_next;
   logic           rd_avail_next;

   // ----------------------------------------------------------
   // handshake and registered result
   // ----------------------------------------------------------
   csr_rd_port u_port (
      .clk           (clk),
      .rst           (rst),
      .req           (req),
      .addr          (addr),
      .mode          (mode),
      .rd_data_next  (rd_data_next),
      .rd_avail_next (rd_avail_next),
      .ack           (ack),
      .lat_addr      (lat_addr),
      .lat_mode      (lat_mode),
      .rd_data       (rd_data),
      .rd_avail      (rd_avail)
   );

   // ----------------------------------------------------------
   // lookup, zero latency
   // ----------------------------------------------------------
   csr_rd_decode u_decode (
      .addr           (lat_addr),
      .sel            (sel),
      .is_cntr_shadow (is_cntr_shadow)
   );

   csr_cntr_access u_access (
      .addr       (lat_addr),
      .mode       (lat_mode),
      .mcounteren (mcounteren),
      .cntr_ok    (cntr_ok)
   );

   csr_rd_mux #(
      .IALIGN16 (IALIGN16),
      .HART_ID  (HART_ID)
   ) u_mux (
      .sel            (sel),
      .is_cntr_shadow (is_cntr_shadow),
      .cntr_ok        (cntr_ok),
      .mstatus        (mstatus),
      .misa           (misa),
      .mtvec          (mtvec),
      .mcounteren     (mcounteren),
      .mcountinhibit  (mcountinhibit),
      .mscratch       (mscratch),
      .mepc           (mepc),
      .mcause         (mcause),
      .mtval          (mtval),
      .mvendorid      (mvendorid),
      .marchid        (marchid),
      .mimpid         (mimpid),
      .mcycle         (mcycle),
      .minstret       (minstret),
      .mtime          (mtime),
      .data           (rd_data_next),
      .exists         (rd_avail_next)
   );

endmodule

//--- testbench/tb_csr_rd_unit.sv
`timescale 1ns/1ns

module tb_csr_rd_unit;
   import csr_pkg::*;

   // hart id given to the DUT and read back through mhartid
   localparam logic [RSZ-1:0] HART = 32'd5;
   // extra cycles req is held after ack to check the frozen result
   localparam int HOLD_CYCLES = 3;
   // edges to wait for an ack transition before giving up
   localparam int ACK_LIMIT = 10;

   logic              clk = 1'b0;
   logic              rst;
   logic              req;
   logic              ack;
   csr_addr_u         addr;
   mode_t             mode;
   logic [RSZ-1:0]    rd_data;
   logic              rd_avail;
   logic [RSZ-1:0]    mstatus;
   logic [RSZ-1:0]    misa;
   logic [RSZ-1:0]    mtvec;
   logic [RSZ-1:0]    mcounteren;
   logic [RSZ-1:0]    mcountinhibit;
   logic [RSZ-1:0]    mscratch;
   logic [RSZ-1:0]    mepc;
   logic [RSZ-1:0]    mcause;
   logic [RSZ-1:0]    mtval;
   logic [RSZ-1:0]    mvendorid;
   logic [RSZ-1:0]    marchid;
   logic [RSZ-1:0]    mimpid;
   logic [2*RSZ-1:0]  mcycle;
   logic [2*RSZ-1:0]  minstret;
   logic [2*RSZ-1:0]  mtime;

   // tests as loaded from the stimulus file
   mode_t             t_mode[$];
   logic [RSZ-1:0]    t_en[$];
   logic [CSR_AW-1:0] t_addr[$];
   logic              t_avail[$];
   string             t_src[$];

   logic [31:0]       lfsr = 32'h73103231;
   int                errors = 0;
   int                watchdog_cycles = 0;

   always #4 clk = ~clk;

   csr_rd_unit #(
      .IALIGN16 (1'b0),
      .HART_ID  (HART)
   ) uut (
      .clk           (clk),
      .rst           (rst),
      .req           (req),
      .ack           (ack),
      .addr          (addr),
      .mode          (mode),
      .rd_data       (rd_data),
      .rd_avail      (rd_avail),
      .mstatus       (mstatus),
      .misa          (misa),
      .mtvec         (mtvec),
      .mcounteren    (mcounteren),
      .mcountinhibit (mcountinhibit),
      .mscratch      (mscratch),
      .mepc          (mepc),
      .mcause        (mcause),
      .mtval         (mtval),
      .mvendorid     (mvendorid),
      .marchid       (marchid),
      .mimpid        (mimpid),
      .mcycle        (mcycle),
      .minstret      (minstret),
      .mtime         (mtime)
   );

   // ----------------------------------------------------------
   // random CSR contents
   // ----------------------------------------------------------
   // galois lfsr stepped once per output bit
   // the high bit is shifted into the word
   function automatic logic [RSZ-1:0] rand_word();
      logic [RSZ-1:0] w;
      w = '0;
      for (int i = 0; i < RSZ; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         w = {w[RSZ-2:0], lfsr[31]};
      end
      return w;
   endfunction

   // value a source name should read from the tb copies of the inputs
   function automatic logic [RSZ-1:0] expected_value(input string src);
      case (src)
         "mstatus":       return mstatus;
         "misa":          return misa;
         "mtvec":         return mtvec;
         "mcounteren":    return mcounteren;
         "mcountinhibit": return mcountinhibit;
         "mscratch":      return mscratch;
         // low two bits of mepc read as zero with 32-bit alignment
         "mepc":          return mepc & ~32'h3;
         "mcause":        return mcause;
         "mtval":         return mtval;
         "cycle_lo":      return mcycle[RSZ-1:0];
         "cycle_hi":      return mcycle[2*RSZ-1:RSZ];
         "instret_lo":    return minstret[RSZ-1:0];
         "instret_hi":    return minstret[2*RSZ-1:RSZ];
         "time_lo":       return mtime[RSZ-1:0];
         "time_hi":       return mtime[2*RSZ-1:RSZ];
         "vendor":        return mvendorid;
         "arch":          return marchid;
         "imp":           return mimpid;
         "hart":          return HART;
         "none":          return '0;
         default:
         begin
            $display("unknown source name %s in stimulus file", src);
            errors++;
            return '0;
         end
      endcase
   endfunction

   // ----------------------------------------------------------
   // checks and handshake helpers
   // ----------------------------------------------------------
   task automatic check_data(input string name, input logic [RSZ-1:0] got,
                             input logic [RSZ-1:0] exp);
      if (got !== exp)
      begin
         $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic check_avail(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("** Error at %0t ns: %s expected %b got %b", $time, name, exp, got);
         errors++;
      end
   endtask

   // sample on falling edges until ack reaches the level
   task automatic wait_ack(input logic level);
      int n;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (ack !== level && n < ACK_LIMIT);
      if (ack !== level)
      begin
         $display("ack did not go to %b within %0d cycles at %0t ns", level, ACK_LIMIT, $time);
         errors++;
      end
   endtask

   // one full four-phase read
   task automatic run_test(input int i);
      logic [RSZ-1:0] exp_data;
      int             err_before;
      err_before = errors;
      @(negedge clk);
      check_avail("ack before req", ack, 1'b0);
      @(posedge clk);
      addr.raw   <= t_addr[i];
      mode       <= t_mode[i];
      mcounteren <= t_en[i];
      req        <= 1'b1;
      wait_ack(1'b1);
      // denied or unknown reads return zero
      exp_data = t_avail[i] ? expected_value(t_src[i]) : '0;
      check_avail("rd_avail", rd_avail, t_avail[i]);
      check_data("rd_data", rd_data, exp_data);
      // req held high stalls the port with the result frozen
      repeat (HOLD_CYCLES)
      begin
         @(negedge clk);
         check_avail("ack (req held)", ack, 1'b1);
         check_data("rd_data (req held)", rd_data, exp_data);
         check_avail("rd_avail (req held)", rd_avail, t_avail[i]);
      end
      @(posedge clk);
      req <= 1'b0;
      wait_ack(1'b0);
      $display("test %0d: mode %0d addr %h %s %s", i, t_mode[i], t_addr[i], t_src[i],
               (errors == err_before) ? "pass" : "FAIL");
   endtask

   // ----------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------
   initial
   begin
      int                fd;
      int                code;
      string             line;
      mode_t             f_mode;
      logic [RSZ-1:0]    f_en;
      logic [CSR_AW-1:0] f_addr;
      logic              f_avail;
      string             f_src;
      rst  = 1'b1;
      req  = 1'b0;
      addr = '0;
      mode = M_MODE;
      mstatus       = rand_word();
      misa          = rand_word();
      mtvec         = rand_word();
      mcounteren    = rand_word();
      mcountinhibit = rand_word();
      mscratch      = rand_word();
      mepc          = rand_word();
      mcause        = rand_word();
      mtval         = rand_word();
      mvendorid     = rand_word();
      marchid       = rand_word();
      mimpid        = rand_word();
      mcycle        = {rand_word(), rand_word()};
      minstret      = {rand_word(), rand_word()};
      mtime         = {rand_word(), rand_word()};

      fd = $fopen("testbench/csr_rd_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the stimulus file");
         errors++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            code = $fgets(line, fd);
            if (code == 0)
               break;
            // comment and blank lines do not scan
            if ($sscanf(line, "%h %h %h %h %s", f_mode, f_en, f_addr, f_avail, f_src) == 5)
            begin
               t_mode.push_back(f_mode);
               t_en.push_back(f_en);
               t_addr.push_back(f_addr);
               t_avail.push_back(f_avail);
               t_src.push_back(f_src);
            end
         end
         $fclose(fd);
      end
      if (t_addr.size() == 0)
      begin
         $display("no tests were loaded from the stimulus file");
         errors++;
      end
      watchdog_cycles = t_addr.size() * 20 + 50;

      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_avail("ack after reset", ack, 1'b0);
      check_avail("rd_avail after reset", rd_avail, 1'b0);
      check_data("rd_data after reset", rd_data, '0);

      for (int i = 0; i < t_addr.size(); i++)
         run_test(i);

      $display("%0d tests run, %0d errors", t_addr.size(), errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // watchdog sized from the number of tests
   initial
   begin
      wait (watchdog_cycles != 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
      $display("Errors found");
      $finish;
   end

endmodule

//--- testbench/csr_rd_stimulus.txt
# columns: mode(hex) mcounteren(hex) csr_addr(hex) expected_avail source
# source is the tb value and half that should come back, none when denied
3 00000000 300 1 mstatus
3 00000000 301 1 misa
3 00000000 305 1 mtvec
3 00000005 306 1 mcounteren
3 00000000 320 1 mcountinhibit
3 00000000 340 1 mscratch
3 00000000 341 1 mepc
3 00000000 342 1 mcause
3 00000000 343 1 mtval
3 00000000 b00 1 cycle_lo
3 00000000 b80 1 cycle_hi
3 00000000 b02 1 instret_lo
3 00000000 b82 1 instret_hi
3 00000000 f11 1 vendor
3 00000000 f12 1 arch
3 00000000 f13 1 imp
3 00000000 f14 1 hart
3 00000000 c00 1 cycle_lo
3 00000000 c81 1 time_hi
3 00000000 c82 1 instret_hi
0 00000001 c80 1 cycle_hi
0 00000006 c00 0 none
1 00000002 c01 1 time_lo
1 00000005 c81 0 none
0 00000004 c02 1 instret_lo
2 ffffffff c00 0 none
3 00000000 100 0 none
3 00000000 3a0 0 none
3 00000000 b03 0 none

//--- csr_rd_unit.f
hdl/csr_pkg.sv
hdl/csr_rd_decode.sv
hdl/csr_cntr_access.sv
hdl/csr_rd_mux.sv
hdl/csr_rd_port.sv
hdl/csr_rd_unit.sv
testbench/tb_csr_rd_unit.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f csr_rd_unit.f \
   --top-module tb_csr_rd_unit -Mdir obj_dir -o tb_csr_rd_unit

out=$(./obj_dir/tb_csr_rd_unit)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
   exit 0
else
   exit 1
fi
